// ==== logic/mt_pkg.sv ====
package mt_pkg;

  // data word
  localparam int WIDTH = 32;

  // virtual banks seen by the address
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;

  // physical banks, one more than virtual for the spare
  localparam int NUMPBNK = 5;
  localparam int BITPBNK = 3;

  // rows in each bank
  localparam int NUMROW = 16;
  localparam int BITROW = 4;

  // logical word address, row above bank
  typedef struct packed {
    logic [BITROW-1:0]  row;
    logic [BITVBNK-1:0] vbnk;
  } mt_vaddr_t;

  // one access presented to a physical bank
  typedef struct packed {
    logic              en;
    logic [BITROW-1:0] row;
    logic [WIDTH-1:0]  data;
  } mt_req_t;

  // bank map of one row
  typedef struct packed {
    logic [NUMVBNK-1:0][BITPBNK-1:0] pbnk;  // physical bank per virtual bank
    logic [BITPBNK-1:0]              free;  // spare bank of this row
  } mt_map_row_t;

endpackage

// ==== logic/mt_map_table.sv ====
`timescale 1ns/10ps

module mt_map_table (
  input  logic                        clk,
  input  logic                        rst_n,
  input  mt_pkg::mt_vaddr_t           rd_addr,
  input  mt_pkg::mt_vaddr_t           wr_addr,
  output logic [mt_pkg::BITPBNK-1:0]  rd_pbnk,
  output logic [mt_pkg::BITPBNK-1:0]  wr_pbnk,
  output logic [mt_pkg::BITPBNK-1:0]  wr_free,
  input  logic                        remap,
  input  logic [mt_pkg::BITPBNK-1:0]  remap_pbnk
);

  // one map entry per row, all held in flops
  mt_pkg::mt_map_row_t map_q [mt_pkg::NUMROW];

  mt_pkg::mt_map_row_t rd_row;
  mt_pkg::mt_map_row_t wr_row;

  // virtual bank v on physical bank v, last bank spare
  function automatic mt_pkg::mt_map_row_t identity_row();
    mt_pkg::mt_map_row_t      r;
    logic [mt_pkg::BITPBNK-1:0] p;
    p = '0;
    for (int v = 0; v < mt_pkg::NUMVBNK; v++) begin
      r.pbnk[v] = p;
      p = p + 1'b1;
    end
    r.free = p;  // ends on NUMVBNK
    return r;
  endfunction

  // lookups for the current cycle
  assign rd_row = map_q[rd_addr.row];
  assign wr_row = map_q[wr_addr.row];

  assign rd_pbnk = rd_row.pbnk[rd_addr.vbnk];
  assign wr_pbnk = wr_row.pbnk[wr_addr.vbnk];
  assign wr_free = wr_row.free;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < mt_pkg::NUMROW; r++) begin
        map_q[r] <= identity_row();
      end
    end else if (remap) begin
      // the write moved to the spare, its old bank becomes the spare
      map_q[wr_addr.row].pbnk[wr_addr.vbnk] <= remap_pbnk;
      map_q[wr_addr.row].free               <= wr_pbnk;
    end
  end

endmodule

// ==== logic/mt_write_steer.sv ====
`timescale 1ns/10ps

module mt_write_steer (
  input  logic                        read,
  input  logic                        write,
  input  logic [mt_pkg::BITPBNK-1:0]  rd_pbnk,
  input  logic [mt_pkg::BITPBNK-1:0]  wr_pbnk,
  input  logic [mt_pkg::BITPBNK-1:0]  wr_free,
  output logic [mt_pkg::BITPBNK-1:0]  wr_target,
  output logic                        wr_en,
  output logic                        remap,
  output logic [mt_pkg::BITPBNK-1:0]  remap_pbnk
);

  logic both_act;
  logic same_bank;
  logic conflict;

  assign both_act  = read & write;
  assign same_bank = (rd_pbnk == wr_pbnk);
  assign conflict  = both_act & same_bank;  // single port already taken by the read

  always_comb begin
    wr_en      = write;
    remap      = 1'b0;
    remap_pbnk = wr_free;
    wr_target  = wr_pbnk;
    if (conflict) begin
      // divert to the spare bank of the row and move the map entry there
      wr_target = wr_free;
      remap     = 1'b1;
    end
  end

endmodule

// ==== logic/mt_bank_arb.sv ====
`timescale 1ns/10ps

module mt_bank_arb #(
  parameter int WIDTH  = 32,
  parameter int NUMROW = 16
) (
  input  logic             clk,
  input  mt_pkg::mt_req_t  rd_req,
  input  mt_pkg::mt_req_t  wr_req,
  output logic [WIDTH-1:0] rd_data
);

  logic [WIDTH-1:0] mem [NUMROW];  // single-port array

  logic                      rd_gnt;
  logic                      wr_gnt;
  logic [mt_pkg::BITROW-1:0] acc_row;

  // fixed priority, read wins the port
  assign rd_gnt = rd_req.en;
  assign wr_gnt = wr_req.en & ~rd_req.en;

  // one address for the one port
  assign acc_row = rd_gnt ? rd_req.row : wr_req.row;

  always_ff @(posedge clk) begin
    if (wr_gnt) begin
      mem[acc_row] <= wr_req.data;
    end
    if (rd_gnt) begin
      rd_data <= mem[acc_row];  // held until the next read of this bank
    end
  end

endmodule

// ==== logic/mt_read_path.sv ====
`timescale 1ns/10ps

module mt_read_path #(
  parameter int WIDTH = 32
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     read,
  input  logic [mt_pkg::BITPBNK-1:0]               rd_pbnk,
  input  logic [mt_pkg::NUMPBNK-1:0][WIDTH-1:0]    bank_data,
  output logic                                     rd_vld,
  output logic [WIDTH-1:0]                         rd_dout
);

  logic                       s1_vld;
  logic [mt_pkg::BITPBNK-1:0] s1_pbnk;  // bank that answers this read
  logic [WIDTH-1:0]           s1_word;

  // stage one runs alongside the bank array read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= read;
    end
  end

  always_ff @(posedge clk) begin
    s1_pbnk <= rd_pbnk;
  end

  always_comb begin
    s1_word = '0;
    for (int b = 0; b < mt_pkg::NUMPBNK; b++) begin
      if (s1_pbnk == b[mt_pkg::BITPBNK-1:0]) begin
        s1_word = bank_data[b];
      end
    end
  end

  // stage two, output register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      rd_dout <= s1_word;
    end
  end

endmodule

// ==== logic/mt_1r1w_top.sv ====
`timescale 1ns/10ps

module mt_1r1w_top #(
  parameter int WIDTH  = mt_pkg::WIDTH,
  parameter int NUMROW = mt_pkg::NUMROW
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              read,
  input  mt_pkg::mt_vaddr_t raddr,
  input  logic              write,
  input  mt_pkg::mt_vaddr_t waddr,
  input  logic [WIDTH-1:0]  din,
  output logic              rd_vld,
  output logic [WIDTH-1:0]  rd_dout
);

  logic [mt_pkg::BITPBNK-1:0] rd_pbnk;
  logic [mt_pkg::BITPBNK-1:0] wr_pbnk;
  logic [mt_pkg::BITPBNK-1:0] wr_free;
  logic [mt_pkg::BITPBNK-1:0] wr_target;
  logic                       wr_en;
  logic                       remap;
  logic [mt_pkg::BITPBNK-1:0] remap_pbnk;

  logic [mt_pkg::NUMPBNK-1:0][WIDTH-1:0] bank_data;

  mt_map_table mt_map_table_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_addr    (raddr),
    .wr_addr    (waddr),
    .rd_pbnk    (rd_pbnk),
    .wr_pbnk    (wr_pbnk),
    .wr_free    (wr_free),
    .remap      (remap),
    .remap_pbnk (remap_pbnk)
  );

  mt_write_steer mt_write_steer_i (
    .read       (read),
    .write      (write),
    .rd_pbnk    (rd_pbnk),
    .wr_pbnk    (wr_pbnk),
    .wr_free    (wr_free),
    .wr_target  (wr_target),
    .wr_en      (wr_en),
    .remap      (remap),
    .remap_pbnk (remap_pbnk)
  );

  for (genvar b = 0; b < mt_pkg::NUMPBNK; b++) begin : g_bank
    localparam logic [mt_pkg::BITPBNK-1:0] BNK = b;

    mt_pkg::mt_req_t rd_req;
    mt_pkg::mt_req_t wr_req;

    // read carries no data into the bank
    assign rd_req = '{en: read && (rd_pbnk == BNK), row: raddr.row, data: '0};
    assign wr_req = '{en: wr_en && (wr_target == BNK), row: waddr.row, data: din};

    mt_bank_arb #(
      .WIDTH  (WIDTH),
      .NUMROW (NUMROW)
    ) mt_bank_arb_i (
      .clk     (clk),
      .rd_req  (rd_req),
      .wr_req  (wr_req),
      .rd_data (bank_data[b])
    );
  end

  mt_read_path #(
    .WIDTH (WIDTH)
  ) mt_read_path_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .read      (read),
    .rd_pbnk   (rd_pbnk),
    .bank_data (bank_data),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

// ==== tests/tb_mt_1r1w.sv ====
`timescale 1ns/10ps

module tb_mt_1r1w;

  localparam int NUMADDR    = 64;
  localparam int SAME_COUNT = 8;

  // cycles spent by each test, used for the timeout limit
  localparam int RESET_CYC  = 2;
  localparam int IDLE_CYC   = 10;
  localparam int FILL_CYC   = 2 * NUMADDR;
  localparam int STRESS_CYC = 200 + NUMADDR;
  localparam int SAME_CYC   = 2 * SAME_COUNT;
  localparam int RAND_CYC   = 2000;
  localparam int DRAIN_CYC  = 4;
  localparam int LIMIT      = RESET_CYC + IDLE_CYC + FILL_CYC + STRESS_CYC + SAME_CYC
                              + RAND_CYC + DRAIN_CYC + 100;

  logic              clk;
  logic              rst_n;
  logic              read;
  mt_pkg::mt_vaddr_t raddr;
  logic              write;
  mt_pkg::mt_vaddr_t waddr;
  logic [31:0]       din;
  logic              rd_vld;
  logic [31:0]       rd_dout;

  int seed;
  int cycle_cnt;

  logic [31:0] shadow [NUMADDR];  // model of the memory contents
  logic [31:0] exp_q [$];          // expected read data, oldest first
  int          due_q [$];          // cycle in which each result shows up

  mt_1r1w_top mt_1r1w_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .read    (read),
    .raddr   (raddr),
    .write   (write),
    .waddr   (waddr),
    .din     (din),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // word of an address before any write in the current cycle
  function automatic logic [31:0] expect_word(input logic [5:0] addr);
    return shadow[addr];
  endfunction

  // one cycle of stimulus, driven just after the rising edge
  task automatic drive_cycle(input logic do_rd, input logic [5:0] ra,
                             input logic do_wr, input logic [5:0] wa,
                             input logic [31:0] data);
    @(posedge clk);
    #1;
    read  = do_rd;
    raddr = ra;
    write = do_wr;
    waddr = wa;
    din   = data;
    if (do_rd) begin
      exp_q.push_back(expect_word(ra));  // taken before the model sees the write
      due_q.push_back(cycle_cnt + 2);
    end
    if (do_wr) begin
      shadow[wa] = data;
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b0, 6'd0, 1'b0, 6'd0, 32'd0);
    end
  endtask

  task automatic read_all();
    logic [5:0] a;
    for (int i = 0; i < NUMADDR; i++) begin
      a = 6'(i);
      drive_cycle(1'b1, a, 1'b0, 6'd0, 32'd0);
    end
  endtask

  // rd_vld must stay low, the comparing process flags any pulse
  task automatic idle_after_reset();
    idle_cycles(IDLE_CYC);
  endtask

  task automatic fill_and_readback();
    logic [5:0]  a;
    logic [31:0] data;
    for (int i = 0; i < NUMADDR; i++) begin
      a    = 6'(i);
      data = 32'hc0de_0000 | (32'(i) << 8) | 32'(~a);
      drive_cycle(1'b0, 6'd0, 1'b1, a, data);
    end
    read_all();
  endtask

  // same virtual bank on both ports, rows differ
  task automatic conflict_stress();
    logic [31:0] r;
    logic [31:0] data;
    logic [1:0]  vbnk;
    logic [3:0]  rrow;
    logic [3:0]  wrow;
    logic [3:0]  delta;
    for (int i = 0; i < 200; i++) begin
      r     = $random(seed);
      data  = $random(seed);
      vbnk  = r[1:0];
      rrow  = r[5:2];
      delta = r[9:6];
      if (delta == 4'd0) begin
        delta = 4'd1;
      end
      wrow = rrow ^ delta;
      drive_cycle(1'b1, {rrow, vbnk}, 1'b1, {wrow, vbnk}, data);
    end
    read_all();
  endtask

  // read and write of one address in one cycle, then read it again
  task automatic same_address();
    logic [31:0] r;
    logic [31:0] data;
    logic [5:0]  a;
    for (int i = 0; i < SAME_COUNT; i++) begin
      r    = $random(seed);
      data = $random(seed);
      a    = r[5:0];
      drive_cycle(1'b1, a, 1'b1, a, data);  // old value expected
      drive_cycle(1'b1, a, 1'b0, 6'd0, 32'd0);
    end
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    logic [31:0] data;
    for (int i = 0; i < RAND_CYC; i++) begin
      r    = $random(seed);
      data = $random(seed);
      drive_cycle(r[0], r[7:2], r[1], r[13:8], data);
    end
  endtask

  // cycle counter and timeout
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > LIMIT) begin
      abort_run($sformatf("timeout: run went past %0d cycles", LIMIT));
    end
  end

  // outputs are sampled at the falling edge, away from the drive time
  always @(negedge clk) begin
    if (rst_n) begin
      if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
        check_value("rd_vld", 32'(rd_vld), 32'd1);
        check_value("rd_dout", rd_dout, exp_q[0]);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end else if (rd_vld) begin
        abort_run($sformatf("rd_vld went high at %0t with no read outstanding", $time));
      end
    end
  end

  initial begin
    seed      = 46036;
    cycle_cnt = 0;
    rst_n     = 1'b0;
    read      = 1'b0;
    raddr     = '0;
    write     = 1'b0;
    waddr     = '0;
    din       = '0;

    repeat (RESET_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;

    idle_after_reset();
    fill_and_readback();
    conflict_stress();
    same_address();
    random_traffic();
    idle_cycles(DRAIN_CYC);

    @(negedge clk);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d reads never returned a result", exp_q.size()));
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== build.f ====
logic/mt_pkg.sv
logic/mt_map_table.sv
logic/mt_write_steer.sv
logic/mt_bank_arb.sv
logic/mt_read_path.sv
logic/mt_1r1w_top.sv
tests/tb_mt_1r1w.sv

// ==== Makefile ====
TOP = tb_mt_1r1w

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o sim_$(TOP)

# the simulator exits with a failing status on $fatal
run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
